//--- hdl/debug_defs.svh
`ifndef DEBUG_DEFS_SVH
`define DEBUG_DEFS_SVH

// Stream and datapath widths
`define DBG_BYTE_W      8
`define DBG_WORD_W      32

// Instruction memory, 4 bytes per word
`define DBG_IM_WORDS    16
`define DBG_IM_AW       4
`define DBG_IM_BYTE_AW  6

// Register bank, addressed by the 4 bit instruction fields
`define DBG_RB_DEPTH    8
`define DBG_RB_AW       4

// Data memory
`define DBG_DM_DEPTH    16
`define DBG_DM_AW       4

`endif

//--- hdl/debug_pkg.sv
`default_nettype none

package debug_pkg;

    `include "debug_defs.svh"

    typedef enum logic [3:0] {
        IDLE,
        LOAD_WAIT,
        LOAD_BYTE,
        READY,
        RUN,
        STEP_WAIT,
        STEP_EXEC,
        SEND_PC,
        SEND_MEM,
        SEND_REGS
    } dbg_state_e;

    // Command bytes from the host
    typedef enum logic [`DBG_BYTE_W-1:0] {
        CMD_LOAD      = 8'd1,
        CMD_STEP_MODE = 8'd2,
        CMD_DUMP_REGS = 8'd3,
        CMD_DUMP_PC   = 8'd4,
        CMD_DUMP_MEM  = 8'd5,
        CMD_STEP      = 8'd6,
        CMD_CONTINUE  = 8'd7,
        CMD_RUN       = 8'd8
    } dbg_cmd_e;

    typedef enum logic [7:0] {
        NOP   = 8'd0,
        ADDI  = 8'd1,
        ADD   = 8'd2,
        STORE = 8'd3,
        HALT  = 8'd255
    } cpu_op_e;

    typedef struct packed {
        cpu_op_e    op;
        logic [3:0] rd;
        logic [3:0] rs;
        logic [3:0] rt;
        logic [3:0] pad;
        logic [7:0] imm;
    } instr_t;

    typedef struct packed {
        logic run_en;   // Free run permission
        logic step;     // One instruction
    } cpu_ctrl_t;

endpackage

`default_nettype wire

//--- hdl/data_mem.sv
`timescale 1ns/1ps
`default_nettype none
`include "debug_defs.svh"

module data_mem (
    input  wire logic                   i_clock,
    input  wire logic                   i_reset,
    input  wire logic                   i_wr,
    input  wire logic [`DBG_BYTE_W-1:0] i_addr,
    input  wire logic [`DBG_BYTE_W-1:0] i_data,
    input  wire logic [`DBG_DM_AW-1:0]  i_dbg_addr,
    output logic [`DBG_BYTE_W-1:0]      o_dbg_data
);

    logic [`DBG_BYTE_W-1:0] mem [0:`DBG_DM_DEPTH-1];

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            for (int i = 0; i < `DBG_DM_DEPTH; i++)
                mem[i] <= '0;
        end else if (i_wr) begin
            mem[i_addr[`DBG_DM_AW-1:0]] <= i_data; // Store address wraps
        end
    end

    assign o_dbg_data = mem[i_dbg_addr];

endmodule

`default_nettype wire

//--- hdl/reg_bank.sv
`timescale 1ns/1ps
`default_nettype none
`include "debug_defs.svh"

module reg_bank (
    input  wire logic                   i_clock,
    input  wire logic                   i_reset,
    input  wire logic                   i_wr,
    input  wire logic [`DBG_RB_AW-1:0]  i_wr_addr,
    input  wire logic [`DBG_WORD_W-1:0] i_wr_data,
    input  wire logic [`DBG_RB_AW-1:0]  i_rs_addr,
    output logic [`DBG_WORD_W-1:0]      o_rs_data,
    input  wire logic [`DBG_RB_AW-1:0]  i_rt_addr,
    output logic [`DBG_WORD_W-1:0]      o_rt_data,
    input  wire logic [`DBG_RB_AW-1:0]  i_dbg_addr,
    output logic [`DBG_WORD_W-1:0]      o_dbg_data
);

    localparam int IDX_W = $clog2(`DBG_RB_DEPTH);

    logic [`DBG_WORD_W-1:0] regs [0:`DBG_RB_DEPTH-1];

    // Upper half of the address space reads as zero
    function automatic logic [`DBG_WORD_W-1:0] read_reg(input logic [`DBG_RB_AW-1:0] addr);
        read_reg = (addr < `DBG_RB_DEPTH) ? regs[addr[IDX_W-1:0]] : '0;
    endfunction

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            for (int i = 0; i < `DBG_RB_DEPTH; i++)
                regs[i] <= '0;
        end else if (i_wr && i_wr_addr < `DBG_RB_DEPTH) begin
            regs[i_wr_addr[IDX_W-1:0]] <= i_wr_data;
        end
    end

    assign o_rs_data  = read_reg(i_rs_addr);
    assign o_rt_data  = read_reg(i_rt_addr);
    assign o_dbg_data = read_reg(i_dbg_addr);

endmodule

`default_nettype wire

//--- hdl/instr_mem.sv
`timescale 1ns/1ps
`default_nettype none
`include "debug_defs.svh"

module instr_mem import debug_pkg::*; (
    input  wire logic                       i_clock,
    input  wire logic                       i_wr,
    input  wire logic [`DBG_IM_BYTE_AW-1:0] i_byte_addr,
    input  wire logic [`DBG_BYTE_W-1:0]     i_byte,
    input  wire logic [`DBG_WORD_W-1:0]     i_pc,
    output instr_t                          o_instr
);

    logic [`DBG_WORD_W-1:0] mem [0:`DBG_IM_WORDS-1];
    logic [`DBG_IM_AW-1:0]  wr_word;
    logic [1:0]             wr_lane;

    assign wr_word = i_byte_addr[`DBG_IM_BYTE_AW-1:2];
    assign wr_lane = i_byte_addr[1:0];

    // Lane 0 is the most significant byte
    always_ff @(posedge i_clock) begin
        if (i_wr)
            mem[wr_word][`DBG_BYTE_W*(3 - wr_lane) +: `DBG_BYTE_W] <= i_byte;
    end

    always_comb begin
        if (i_pc < `DBG_IM_WORDS)
            o_instr = instr_t'(mem[i_pc[`DBG_IM_AW-1:0]]);
        else
            o_instr = '0; // NOP past the end
    end

endmodule

`default_nettype wire

//--- hdl/mini_cpu.sv
`timescale 1ns/1ps
`default_nettype none
`include "debug_defs.svh"

module mini_cpu import debug_pkg::*; (
    input  wire logic                   i_clock,
    input  wire logic                   i_reset,
    input  wire cpu_ctrl_t              i_ctrl,
    input  wire instr_t                 i_instr,
    output logic [`DBG_WORD_W-1:0]      o_pc,
    output logic                        o_halt,
    output logic                        o_rb_wr,
    output logic [`DBG_RB_AW-1:0]       o_rb_wr_addr,
    output logic [`DBG_WORD_W-1:0]      o_rb_wr_data,
    output logic [`DBG_RB_AW-1:0]       o_rs_addr,
    output logic [`DBG_RB_AW-1:0]       o_rt_addr,
    input  wire logic [`DBG_WORD_W-1:0] i_rs_data,
    input  wire logic [`DBG_WORD_W-1:0] i_rt_data,
    output logic                        o_dm_wr,
    output logic [`DBG_BYTE_W-1:0]      o_dm_addr,
    output logic [`DBG_BYTE_W-1:0]      o_dm_data
);

    logic [`DBG_WORD_W-1:0] pc;
    logic                   halt;
    logic                   exec;

    // One instruction per permitted cycle
    assign exec = (i_ctrl.run_en || i_ctrl.step) && !halt;

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            pc   <= '0;
            halt <= 1'b0;
        end else if (exec) begin
            if (i_instr.op == HALT)
                halt <= 1'b1;   // PC stays on the HALT
            else
                pc <= pc + 1'b1;
        end
    end

    always_comb begin
        o_rb_wr      = 1'b0;
        o_rb_wr_data = '0;
        o_dm_wr      = 1'b0;
        case (i_instr.op)
            ADDI: begin
                o_rb_wr      = exec;
                o_rb_wr_data = i_rs_data + `DBG_WORD_W'(i_instr.imm);
            end
            ADD: begin
                o_rb_wr      = exec;
                o_rb_wr_data = i_rs_data + i_rt_data;
            end
            STORE:   o_dm_wr = exec;
            default: o_rb_wr = 1'b0; // NOP, HALT and unknown codes
        endcase
    end

    assign o_pc         = pc;
    assign o_halt       = halt;
    assign o_rb_wr_addr = i_instr.rd;
    assign o_rs_addr    = i_instr.rs;
    assign o_rt_addr    = i_instr.rt;
    assign o_dm_addr    = i_instr.imm;
    assign o_dm_data    = i_rs_data[`DBG_BYTE_W-1:0];

    // Debug unit never grants both at once
    a_ctrl_onehot: assert property (@(posedge i_clock) disable iff (i_reset)
        !(i_ctrl.run_en && i_ctrl.step));

endmodule

`default_nettype wire

//--- hdl/debug_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "debug_defs.svh"

module debug_unit import debug_pkg::*; (
    input  wire logic                       i_clock,
    input  wire logic                       i_reset,
    input  wire logic                       i_rx_valid,
    input  wire logic [`DBG_BYTE_W-1:0]     i_rx_data,
    input  wire logic                       i_tx_done,
    input  wire logic                       i_halt,
    input  wire logic [`DBG_WORD_W-1:0]     i_pc,
    input  wire logic [`DBG_WORD_W-1:0]     i_rb_data,
    input  wire logic [`DBG_BYTE_W-1:0]     i_dm_data,
    output logic                            o_tx_start,
    output logic [`DBG_BYTE_W-1:0]          o_tx_data,
    output logic                            o_im_wr,
    output logic [`DBG_IM_BYTE_AW-1:0]      o_im_byte_addr,
    output logic [`DBG_BYTE_W-1:0]          o_im_byte,
    output logic [`DBG_RB_AW-1:0]           o_rb_addr,
    output logic [`DBG_DM_AW-1:0]           o_dm_addr,
    output cpu_ctrl_t                       o_cpu_ctrl
);

    dbg_state_e                 state;
    dbg_state_e                 next_state;
    dbg_state_e                 ret_state;      // Where a plain dump goes back to
    dbg_cmd_e                   rx_cmd;
    logic                       step_reply;     // Dump is part of a step reply
    logic [`DBG_IM_BYTE_AW-1:0] load_cnt;
    logic [`DBG_BYTE_W-1:0]     load_byte;
    logic [`DBG_DM_AW-1:0]      idx;            // Memory byte or register index
    logic [1:0]                 byte_sel;       // Byte within a word, MSB first
    logic                       tx_take;
    logic                       last_byte;
    logic                       load_last;

    function automatic logic [`DBG_BYTE_W-1:0] be_byte(
        input logic [`DBG_WORD_W-1:0] word,
        input logic [1:0]             sel
    );
        be_byte = word[`DBG_BYTE_W*(3 - sel) +: `DBG_BYTE_W];
    endfunction

    assign rx_cmd    = dbg_cmd_e'(i_rx_data);
    assign tx_take   = o_tx_start && i_tx_done;
    assign last_byte = (byte_sel == 2'd3);
    assign load_last = (load_cnt == `DBG_IM_WORDS*4 - 1);

    always_comb begin
        next_state = state;
        case (state)
            IDLE, READY: begin
                if (i_rx_valid) begin
                    case (rx_cmd)
                        CMD_LOAD:      next_state = LOAD_WAIT;
                        CMD_DUMP_PC:   next_state = SEND_PC;
                        CMD_DUMP_MEM:  next_state = SEND_MEM;
                        CMD_DUMP_REGS: next_state = SEND_REGS;
                        CMD_STEP_MODE: begin
                            if (state == READY)
                                next_state = STEP_WAIT;
                        end
                        CMD_RUN: begin
                            if (state == READY)
                                next_state = RUN;
                        end
                        default:       next_state = state; // Unknown code dropped
                    endcase
                end
            end
            LOAD_WAIT: begin
                if (i_rx_valid)
                    next_state = LOAD_BYTE;
            end
            LOAD_BYTE: begin
                if (load_last)
                    next_state = READY;
                else if (!i_rx_valid)
                    next_state = LOAD_WAIT;
            end
            RUN: begin
                if (i_halt)
                    next_state = IDLE;
            end
            STEP_WAIT: begin
                if (i_rx_valid && rx_cmd == CMD_STEP)
                    next_state = STEP_EXEC;
                else if (i_rx_valid && rx_cmd == CMD_CONTINUE)
                    next_state = RUN;
            end
            STEP_EXEC: next_state = SEND_PC;
            SEND_PC: begin
                if (tx_take && last_byte)
                    next_state = step_reply ? SEND_MEM : ret_state;
            end
            SEND_MEM: begin
                if (tx_take && idx == `DBG_DM_DEPTH - 1)
                    next_state = step_reply ? SEND_REGS : ret_state;
            end
            SEND_REGS: begin
                if (tx_take && last_byte && idx == `DBG_RB_DEPTH - 1)
                    next_state = step_reply ? STEP_WAIT : ret_state;
            end
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state      <= IDLE;
            ret_state  <= IDLE;
            step_reply <= 1'b0;
            load_cnt   <= '0;
            idx        <= '0;
            byte_sel   <= '0;
        end else begin
            state <= next_state;

            // Dump counters restart on every state change
            if (state != next_state) begin
                idx      <= '0;
                byte_sel <= '0;
            end else if (tx_take) begin
                if (state != SEND_MEM)
                    byte_sel <= byte_sel + 1'b1;
                if (state == SEND_MEM || (state == SEND_REGS && last_byte))
                    idx <= idx + 1'b1;
            end

            if (state == STEP_EXEC) begin
                step_reply <= 1'b1;
            end else if (state != next_state && (state == IDLE || state == READY)) begin
                ret_state  <= state;
                step_reply <= 1'b0;
            end

            if (state != LOAD_BYTE && next_state == LOAD_WAIT && state != LOAD_WAIT)
                load_cnt <= '0;
            else if (state == LOAD_BYTE)
                load_cnt <= load_cnt + 1'b1;
        end
    end

    // Latest program byte, written in LOAD_BYTE
    always_ff @(posedge i_clock) begin
        if (i_rx_valid && (state == LOAD_WAIT || state == LOAD_BYTE))
            load_byte <= i_rx_data;
    end

    always_comb begin
        case (state)
            SEND_PC:   o_tx_data = be_byte(i_pc, byte_sel);
            SEND_MEM:  o_tx_data = i_dm_data;
            SEND_REGS: o_tx_data = be_byte(i_rb_data, byte_sel);
            default:   o_tx_data = '0;
        endcase
    end

    assign o_tx_start        = (state == SEND_PC) || (state == SEND_MEM) || (state == SEND_REGS);
    assign o_im_wr           = (state == LOAD_BYTE);
    assign o_im_byte_addr    = load_cnt;
    assign o_im_byte         = load_byte;
    assign o_rb_addr         = idx;
    assign o_dm_addr         = idx;
    assign o_cpu_ctrl.run_en = (state == RUN);
    assign o_cpu_ctrl.step   = (state == STEP_EXEC);

    // Byte held until the host takes it
    a_tx_hold: assert property (@(posedge i_clock) disable iff (i_reset)
        (o_tx_start && !i_tx_done) |=> (o_tx_start && $stable(o_tx_data)));

    // Every program write follows one received byte
    a_load_per_byte: assert property (@(posedge i_clock) disable iff (i_reset)
        o_im_wr |-> $past(i_rx_valid));

endmodule

`default_nettype wire

//--- hdl/debug_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "debug_defs.svh"

module debug_top import debug_pkg::*; (
    input  wire logic                   i_clock,
    input  wire logic                   i_reset,
    input  wire logic                   i_rx_valid,
    input  wire logic [`DBG_BYTE_W-1:0] i_rx_data,
    output logic                        o_tx_start,
    output logic [`DBG_BYTE_W-1:0]      o_tx_data,
    input  wire logic                   i_tx_done,
    output logic                        o_halted
);

    cpu_ctrl_t                  cpu_ctrl;
    instr_t                     instr;
    logic [`DBG_WORD_W-1:0]     pc;
    logic                       halt;
    logic                       im_wr;
    logic [`DBG_IM_BYTE_AW-1:0] im_byte_addr;
    logic [`DBG_BYTE_W-1:0]     im_byte;
    logic [`DBG_RB_AW-1:0]      rb_dbg_addr;
    logic [`DBG_WORD_W-1:0]     rb_dbg_data;
    logic [`DBG_DM_AW-1:0]      dm_dbg_addr;
    logic [`DBG_BYTE_W-1:0]     dm_dbg_data;
    logic                       rb_wr;
    logic [`DBG_RB_AW-1:0]      rb_wr_addr;
    logic [`DBG_WORD_W-1:0]     rb_wr_data;
    logic [`DBG_RB_AW-1:0]      rs_addr;
    logic [`DBG_RB_AW-1:0]      rt_addr;
    logic [`DBG_WORD_W-1:0]     rs_data;
    logic [`DBG_WORD_W-1:0]     rt_data;
    logic                       dm_wr;
    logic [`DBG_BYTE_W-1:0]     dm_addr;
    logic [`DBG_BYTE_W-1:0]     dm_data;

    debug_unit u_debug (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_rx_valid     (i_rx_valid),
        .i_rx_data      (i_rx_data),
        .i_tx_done      (i_tx_done),
        .i_halt         (halt),
        .i_pc           (pc),
        .i_rb_data      (rb_dbg_data),
        .i_dm_data      (dm_dbg_data),
        .o_tx_start     (o_tx_start),
        .o_tx_data      (o_tx_data),
        .o_im_wr        (im_wr),
        .o_im_byte_addr (im_byte_addr),
        .o_im_byte      (im_byte),
        .o_rb_addr      (rb_dbg_addr),
        .o_dm_addr      (dm_dbg_addr),
        .o_cpu_ctrl     (cpu_ctrl)
    );

    mini_cpu u_cpu (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_ctrl       (cpu_ctrl),
        .i_instr      (instr),
        .o_pc         (pc),
        .o_halt       (halt),
        .o_rb_wr      (rb_wr),
        .o_rb_wr_addr (rb_wr_addr),
        .o_rb_wr_data (rb_wr_data),
        .o_rs_addr    (rs_addr),
        .o_rt_addr    (rt_addr),
        .i_rs_data    (rs_data),
        .i_rt_data    (rt_data),
        .o_dm_wr      (dm_wr),
        .o_dm_addr    (dm_addr),
        .o_dm_data    (dm_data)
    );

    instr_mem u_imem (
        .i_clock     (i_clock),
        .i_wr        (im_wr),
        .i_byte_addr (im_byte_addr),
        .i_byte      (im_byte),
        .i_pc        (pc),
        .o_instr     (instr)
    );

    reg_bank u_regs (
        .i_clock    (i_clock),
        .i_reset    (i_reset),
        .i_wr       (rb_wr),
        .i_wr_addr  (rb_wr_addr),
        .i_wr_data  (rb_wr_data),
        .i_rs_addr  (rs_addr),
        .o_rs_data  (rs_data),
        .i_rt_addr  (rt_addr),
        .o_rt_data  (rt_data),
        .i_dbg_addr (rb_dbg_addr),
        .o_dbg_data (rb_dbg_data)
    );

    data_mem u_dmem (
        .i_clock    (i_clock),
        .i_reset    (i_reset),
        .i_wr       (dm_wr),
        .i_addr     (dm_addr),
        .i_data     (dm_data),
        .i_dbg_addr (dm_dbg_addr),
        .o_dbg_data (dm_dbg_data)
    );

    assign o_halted = halt;

endmodule

`default_nettype wire

//--- bench/debug_top_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "debug_defs.svh"

module debug_top_tb import debug_pkg::*; ();

    localparam int REPLY_MAX = 4 + `DBG_DM_DEPTH + 4*`DBG_RB_DEPTH;
    localparam int STEPS     = 5;
    localparam logic [2:0] PART_NONE  = 3'b000;
    localparam logic [2:0] PART_PC    = 3'b100;
    localparam logic [2:0] PART_MEM   = 3'b010;
    localparam logic [2:0] PART_REGS  = 3'b001;
    localparam logic [2:0] STEP_REPLY = 3'b111;

    typedef struct packed {
        logic [7:0]                  cmd;
        logic                        wait_halt;  // Command ends with a run to HALT
        logic [7:0]                  len;
        logic [REPLY_MAX-1:0][7:0]   data;
    } row_t;

    logic        clock;
    logic        reset;
    logic        rx_valid;
    logic [7:0]  rx_data;
    logic        tx_start;
    logic [7:0]  tx_data;
    logic        tx_done;
    logic        halted;

    logic [31:0] prog [0:`DBG_IM_WORDS-1];
    logic [31:0] m_pc;
    logic [31:0] m_regs [0:`DBG_RB_DEPTH-1];
    logic [7:0]  m_dmem [0:`DBG_DM_DEPTH-1];
    logic        m_halt;
    row_t        rows [$];
    int          cycle_cnt = 0;
    int          cycle_limit = 0;

    debug_top dut0 (
        .i_clock    (clock),
        .i_reset    (reset),
        .i_rx_valid (rx_valid),
        .i_rx_data  (rx_data),
        .o_tx_start (tx_start),
        .o_tx_data  (tx_data),
        .i_tx_done  (tx_done),
        .o_halted   (halted)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    always @(posedge clock)
        cycle_cnt <= cycle_cnt + 1;

    initial begin
        wait (cycle_limit > 0 && cycle_cnt >= cycle_limit);
        report_failure($sformatf("Timeout at %0t after %0d cycles, DUT stopped responding",
                                 $time, cycle_cnt));
    end

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string sig, input logic [7:0] exp,
                                   input logic [7:0] got);
        report_failure($sformatf("[ERROR] time %0t: %s expected 0x%02h, actual 0x%02h",
                                 $time, sig, exp, got));
    endtask

    task automatic tick();
        @(posedge clock);
        #1;
    endtask

    // ISA reference model
    function automatic logic [31:0] model_reg(input logic [3:0] a);
        return a[3] ? 32'd0 : m_regs[a[2:0]];
    endfunction

    task automatic set_model_reg(input logic [3:0] a, input logic [31:0] v);
        if (!a[3])
            m_regs[a[2:0]] = v;
    endtask

    task automatic model_exec();
        instr_t      ins;
        logic [31:0] a;
        logic [31:0] b;
        ins = instr_t'(prog[m_pc[3:0]]);
        a = model_reg(ins.rs);
        b = model_reg(ins.rt);
        case (ins.op)
            ADDI:    set_model_reg(ins.rd, a + {24'd0, ins.imm});
            ADD:     set_model_reg(ins.rd, a + b);
            STORE:   m_dmem[ins.imm[3:0]] = a[7:0];  // Low 4 address bits only
            HALT:    m_halt = 1'b1;
            default: ;
        endcase
        if (ins.op != HALT)
            m_pc = m_pc + 32'd1;
    endtask

    task automatic add_row(input logic [7:0] cmd, input logic wait_halt,
                           input logic [2:0] parts);
        row_t r;
        int   n;
        r = '0;
        r.cmd = cmd;
        r.wait_halt = wait_halt;
        n = 0;
        if (parts[2]) begin
            for (int b = 0; b < 4; b++) begin
                r.data[n] = m_pc[8*(3-b) +: 8];
                n++;
            end
        end
        if (parts[1]) begin
            for (int a = 0; a < `DBG_DM_DEPTH; a++) begin
                r.data[n] = m_dmem[a];
                n++;
            end
        end
        if (parts[0]) begin
            for (int a = 0; a < `DBG_RB_DEPTH; a++) begin
                for (int b = 0; b < 4; b++) begin
                    r.data[n] = m_regs[a][8*(3-b) +: 8];
                    n++;
                end
            end
        end
        r.len = 8'(n);
        rows.push_back(r);
    endtask

    task automatic build_table();
        // op rd rs rt pad imm
        prog[0]  = 32'h0110_0005;  // ADDI r1, r0, 5
        prog[1]  = 32'h0120_007f;  // ADDI r2, r0, 0x7f
        prog[2]  = 32'h0231_2000;  // ADD r3, r1, r2
        prog[3]  = 32'h0303_0002;  // STORE r3 -> [2]
        prog[4]  = 32'h0143_00ff;  // ADDI r4, r3, 0xff
        prog[5]  = 32'h0254_4000;  // ADD r5, r4, r4
        prog[6]  = 32'h0305_0007;  // STORE r5 -> [7]
        prog[7]  = 32'h0265_3000;  // ADD r6, r5, r3
        prog[8]  = 32'h0176_0010;  // ADDI r7, r6, 0x10
        prog[9]  = 32'h0307_000f;  // STORE r7 -> [15]
        prog[10] = 32'h0211_7000;  // ADD r1, r1, r7
        prog[11] = 32'h0301_0013;  // STORE r1 -> [0x13], wraps to 3
        prog[12] = 32'h0122_0080;  // ADDI r2, r2, 0x80
        prog[13] = 32'h0202_1000;  // ADD r0, r2, r1
        prog[14] = 32'h0300_0000;  // STORE r0 -> [0]
        prog[15] = 32'hff00_0000;  // HALT
        m_pc = '0;
        m_halt = 1'b0;
        foreach (m_regs[i]) m_regs[i] = '0;
        foreach (m_dmem[i]) m_dmem[i] = '0;

        add_row(8'h55, 1'b0, PART_NONE);  // Unknown code, dropped
        add_row(CMD_LOAD, 1'b0, PART_NONE);
        for (int w = 0; w < `DBG_IM_WORDS; w++)
            for (int l = 0; l < 4; l++)
                add_row(prog[w][8*(3-l) +: 8], 1'b0, PART_NONE);
        add_row(CMD_DUMP_MEM, 1'b0, PART_MEM);
        add_row(CMD_DUMP_PC, 1'b0, PART_PC);
        add_row(CMD_STEP_MODE, 1'b0, PART_NONE);
        repeat (STEPS) begin
            model_exec();
            add_row(CMD_STEP, 1'b0, STEP_REPLY);
        end
        add_row(CMD_CONTINUE, 1'b1, PART_NONE);
        while (!m_halt)
            model_exec();
        add_row(CMD_DUMP_REGS, 1'b0, PART_REGS);
        add_row(CMD_DUMP_MEM, 1'b0, PART_MEM);
        add_row(CMD_DUMP_PC, 1'b0, PART_PC);
    endtask

    task automatic send_byte(input logic [7:0] b);
        rx_data  = b;
        rx_valid = 1'b1;
        tick();
        rx_valid = 1'b0;
        rx_data  = '0;
    endtask

    // Host side of the transmit handshake, random acknowledge delay
    task automatic take_byte(input logic [7:0] exp, input int k);
        int unsigned delay;
        while (!tx_start)
            tick();
        delay = $urandom % 6;
        repeat (delay) begin
            tick();
            assert (tx_start) else report_failure("o_tx_start dropped before acknowledge");
        end
        assert (tx_data == exp)
            else report_mismatch($sformatf("o_tx_data (byte %0d)", k), exp, tx_data);
        tx_done = 1'b1;
        tick();
        tx_done = 1'b0;
    endtask

    task automatic expect_quiet(input int n);
        repeat (n) begin
            assert (!tx_start) else report_mismatch("o_tx_start", 8'd0, 8'(tx_start));
            tick();
        end
    endtask

    task automatic apply_row(input row_t r);
        if (r.wait_halt)
            assert (!halted) else report_mismatch("o_halted", 8'd0, 8'(halted));
        send_byte(r.cmd);
        if (r.wait_halt) begin
            while (!halted) begin
                assert (!tx_start) else report_mismatch("o_tx_start", 8'd0, 8'(tx_start));
                tick();
            end
            tick();  // Unit leaves RUN one cycle after halt
        end
        for (int k = 0; k < int'(r.len); k++)
            take_byte(r.data[k], k);
        expect_quiet(6);
    endtask

    initial begin
        int total;
        void'($urandom(32'h53c3_791b));
        reset    = 1'b1;
        rx_valid = 1'b0;
        rx_data  = '0;
        tx_done  = 1'b0;
        build_table();
        total = 0;
        foreach (rows[i]) total += int'(rows[i].len);
        cycle_limit = total * 8 + 2000;

        repeat (3) @(posedge clock);
        #1;
        reset = 1'b0;
        repeat (10) begin
            tick();
            assert (!tx_start) else report_mismatch("o_tx_start", 8'd0, 8'(tx_start));
            assert (!halted) else report_mismatch("o_halted", 8'd0, 8'(halted));
        end

        foreach (rows[i]) apply_row(rows[i]);

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+hdl
hdl/debug_pkg.sv
hdl/data_mem.sv
hdl/reg_bank.sv
hdl/instr_mem.sv
hdl/mini_cpu.sv
hdl/debug_unit.sv
hdl/debug_top.sv
bench/debug_top_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the debug subsystem testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f project.f --top-module debug_top_tb; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vdebug_top_tb 2>&1)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qF '*** TEST PASSED ***'; then
    exit 0
fi

echo "Pass message not found in simulation output"
exit 1
